/* sources.f */
hw/sdr_pkg.sv
hw/sdr_reset_ctrl.sv
hw/sdr_credit_tx.sv
hw/sdr_credit_rx.sv
hw/sdr_link_north.sv
hw/sdr_north_edge.sv
sim/tb_sdr_north_edge.sv

/* Makefile */
# Verilator build and run for the north edge testbench

VERILATOR ?= verilator
TOP       ?= tb_sdr_north_edge
FLAGS     ?= --assert
BUILD_DIR ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FLAGS, BUILD_DIR"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_sdr_north_edge.sv */
`default_nettype none

module tb_sdr_north_edge;

  localparam int NC          = sdr_pkg::NUM_COLS;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 400;
  localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES + 1600; // Margin on top of six tests

  logic clk = 1'b0;
  logic arst_n = 1'b0;
  logic [NC-1:0] core_reset = '0;
  logic [NC-1:0][1:0] core_reset_o;
  sdr_pkg::link_sif_s [NC-1:0] sif_in = '0;
  sdr_pkg::link_sif_s [NC-1:0] sif_out;
  logic [NC-1:0][sdr_pkg::X_W-1:0] gx_in = '0;
  logic [NC-1:0][sdr_pkg::Y_W-1:0] gy_in = '0;
  logic [NC-1:0][sdr_pkg::X_W-1:0] gx_out;
  logic [NC-1:0][sdr_pkg::Y_W-1:0] gy_out;
  logic async_up = 1'b0;
  logic async_dn = 1'b0;
  logic [NC-1:0] fwd_i_dis = '0;
  logic [NC-1:0] fwd_o_dis = '0;
  logic [NC-1:0] rev_i_dis = '0;
  logic [NC-1:0] rev_o_dis = '0;

  // Each link output feeds the matching input of the same column
  sdr_pkg::fwd_packet_s [NC-1:0] fwd_data;
  sdr_pkg::rev_packet_s [NC-1:0] rev_data;
  logic [NC-1:0] fwd_v, fwd_tok, rev_v, rev_tok;

  int cycle = 0;
  int chk_errors = 0;
  int test_errors = 0;
  int fwd_req [NC] = '{default: 0};
  int rev_req [NC] = '{default: 0};
  int fwd_sent [NC] = '{default: 0};
  int rev_sent [NC] = '{default: 0};
  sdr_pkg::fwd_packet_s fwd_q [NC][$];
  sdr_pkg::rev_packet_s rev_q [NC][$];
  int fwd_t [NC][$];
  int rev_t [NC][$];
  int ready_mode = 0; // 0 always ready, 1 held low, 2 random stalls
  logic lat_chk = 1'b0;
  logic quiet_chk = 1'b0;
  logic dis_chk = 1'b0;
  logic past_ok = 1'b0;
  logic [NC-1:0] rst_q = '0;
  logic [NC-1:0][sdr_pkg::X_W-1:0] gx_q = '0;
  logic [NC-1:0][sdr_pkg::Y_W-1:0] gy_q = '0;

  sdr_north_edge sdr_north_edge_i (
    .core_clk_i (clk), .arst_n_i (arst_n),
    .core_reset_i (core_reset), .core_reset_o (core_reset_o),
    .core_link_sif_i (sif_in), .core_link_sif_o (sif_out),
    .core_global_x_i (gx_in), .core_global_y_i (gy_in),
    .core_global_x_o (gx_out), .core_global_y_o (gy_out),
    .async_uplink_reset_i (async_up), .async_downstream_reset_i (async_dn),
    .fwd_link_i_disable_i (fwd_i_dis), .fwd_link_o_disable_i (fwd_o_dis),
    .rev_link_i_disable_i (rev_i_dis), .rev_link_o_disable_i (rev_o_dis),
    .io_fwd_link_data_o (fwd_data), .io_fwd_link_v_o (fwd_v), .io_fwd_link_token_i (fwd_tok),
    .io_fwd_link_data_i (fwd_data), .io_fwd_link_v_i (fwd_v), .io_fwd_link_token_o (fwd_tok),
    .io_rev_link_data_o (rev_data), .io_rev_link_v_o (rev_v), .io_rev_link_token_i (rev_tok),
    .io_rev_link_data_i (rev_data), .io_rev_link_v_i (rev_v), .io_rev_link_token_o (rev_tok)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic void show_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
  endfunction

  function automatic sdr_pkg::fwd_packet_s random_fwd();
    logic [31:0] r;
    r = $urandom;
    return r[$bits(sdr_pkg::fwd_packet_s)-1:0];
  endfunction

  function automatic sdr_pkg::rev_packet_s random_rev();
    logic [31:0] r;
    r = $urandom;
    return r[$bits(sdr_pkg::rev_packet_s)-1:0];
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Source packets, record accepts and compare what comes back out of each FIFO
  always @(posedge clk) begin : drive_and_score
    sdr_pkg::fwd_packet_s fexp;
    sdr_pkg::rev_packet_s rexp;
    int t;
    logic acc;
    for (int c = 0; c < NC; c++) begin
      acc = sif_in[c].fwd.v && sif_out[c].fwd.ready_and_rev;
      if (acc) begin
        fwd_q[c].push_back(sif_in[c].fwd.data);
        fwd_t[c].push_back(cycle);
        fwd_sent[c]++;
      end
      if (fwd_req[c] == fwd_sent[c]) sif_in[c].fwd.v <= 1'b0;
      else if (!sif_in[c].fwd.v || acc) begin
        sif_in[c].fwd.v    <= ($urandom_range(3) != 0);
        sif_in[c].fwd.data <= random_fwd();
      end
      acc = sif_in[c].rev.v && sif_out[c].rev.ready_and_rev;
      if (acc) begin
        rev_q[c].push_back(sif_in[c].rev.data);
        rev_t[c].push_back(cycle);
        rev_sent[c]++;
      end
      if (rev_req[c] == rev_sent[c]) sif_in[c].rev.v <= 1'b0;
      else if (!sif_in[c].rev.v || acc) begin
        sif_in[c].rev.v    <= ($urandom_range(3) != 0);
        sif_in[c].rev.data <= random_rev();
      end

      if (sif_out[c].fwd.v && sif_in[c].fwd.ready_and_rev) begin
        if (fwd_q[c].size() == 0) begin
          $display("Column %0d delivered a forward packet that was never sent", c);
          chk_errors++;
        end else begin
          fexp = fwd_q[c].pop_front();
          t = fwd_t[c].pop_front();
          assert (sif_out[c].fwd.data == fexp) else begin
            show_mismatch($sformatf("core_link_sif_o[%0d].fwd.data", c), fexp,
                          sif_out[c].fwd.data);
            chk_errors++;
          end
          assert (!lat_chk || cycle - t == 2) else begin
            show_mismatch($sformatf("fwd latency col %0d", c), 2, cycle - t);
            chk_errors++;
          end
        end
      end
      if (sif_out[c].rev.v && sif_in[c].rev.ready_and_rev) begin
        if (rev_q[c].size() == 0) begin
          $display("Column %0d delivered a reverse packet that was never sent", c);
          chk_errors++;
        end else begin
          rexp = rev_q[c].pop_front();
          t = rev_t[c].pop_front();
          assert (sif_out[c].rev.data == rexp) else begin
            show_mismatch($sformatf("core_link_sif_o[%0d].rev.data", c), rexp,
                          sif_out[c].rev.data);
            chk_errors++;
          end
          assert (!lat_chk || cycle - t == 2) else begin
            show_mismatch($sformatf("rev latency col %0d", c), 2, cycle - t);
            chk_errors++;
          end
        end
      end
      sif_in[c].fwd.ready_and_rev <= (ready_mode == 0) ||
                                     (ready_mode == 2 && $urandom_range(1) == 1);
      sif_in[c].rev.ready_and_rev <= (ready_mode == 0) ||
                                     (ready_mode == 2 && $urandom_range(1) == 1);
    end
  end

  // Registered pass-through, quiet state and disable rules
  always @(posedge clk) begin : check_rules
    past_ok <= arst_n;
    for (int c = 0; c < NC; c++) begin
      if (past_ok) begin
        assert (core_reset_o[c] == {2{rst_q[c]}}) else begin
          show_mismatch($sformatf("core_reset_o[%0d]", c), {2{rst_q[c]}}, core_reset_o[c]);
          chk_errors++;
        end
        assert (gx_out[c] == gx_q[c] && gy_out[c] == gy_q[c]) else begin
          show_mismatch($sformatf("core_global_x_o/y_o[%0d]", c), {gx_q[c], gy_q[c]},
                        {gx_out[c], gy_out[c]});
          chk_errors++;
        end
      end
      if (quiet_chk) begin
        assert (!fwd_v[c] && !rev_v[c] && !fwd_tok[c] && !rev_tok[c] &&
                !sif_out[c].fwd.v && !sif_out[c].rev.v) else begin
          show_mismatch($sformatf("link/core valids col %0d", c), 0,
                        {fwd_v[c], rev_v[c], fwd_tok[c], rev_tok[c],
                         sif_out[c].fwd.v, sif_out[c].rev.v});
          chk_errors++;
        end
      end
      rst_q[c] <= core_reset[c];
      gx_q[c]  <= gx_in[c];
      gy_q[c]  <= gy_in[c];
    end
    if (dis_chk) begin
      assert (!sif_out[1].fwd.ready_and_rev && !fwd_v[1]) else begin
        show_mismatch("core_link_sif_o[1].fwd.ready_and_rev/io_fwd_link_v_o[1]", 0,
                      {sif_out[1].fwd.ready_and_rev, fwd_v[1]});
        chk_errors++;
      end
    end
  end

  function automatic logic traffic_idle();
    for (int c = 0; c < NC; c++) begin
      if (fwd_req[c] != fwd_sent[c] || rev_req[c] != rev_sent[c]) return 1'b0;
      if (fwd_q[c].size() != 0 || rev_q[c].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic wait_idle();
    @(negedge clk);
    while (!traffic_idle()) @(negedge clk);
  endtask

  task automatic end_test(int num, string name);
    $display("test %0d %s finished, errors so far %0d", num, name, chk_errors + test_errors);
  endtask

  initial begin
    int base_f;
    int base_r;
    void'($urandom(43404));
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    // The link stays quiet while core reset toggles
    @(negedge clk);
    quiet_chk = 1'b1;
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      core_reset <= (i < 3 || i == 5) ? '1 : '0;
    end
    @(negedge clk);
    quiet_chk = 1'b0;
    end_test(1, "reset state");

    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      for (int c = 0; c < NC; c++) begin
        gx_in[c] <= sdr_pkg::X_W'($urandom_range(15));
        gy_in[c] <= sdr_pkg::Y_W'($urandom_range(7));
      end
    end
    end_test(2, "coordinates");

    @(negedge clk);
    lat_chk = 1'b1;
    for (int c = 0; c < NC; c++) fwd_req[c] += 20;
    wait_idle();
    end_test(3, "forward loopback");

    for (int c = 0; c < NC; c++) begin
      rev_req[c] += 16;
      fwd_req[c] += 16;
    end
    wait_idle();
    lat_chk = 1'b0;
    end_test(4, "reverse loopback");

    // Ten packets are offered against eight credits
    ready_mode = 1;
    base_f = fwd_sent[0];
    base_r = rev_sent[0];
    fwd_req[0] += 10;
    rev_req[0] += 10;
    while (fwd_sent[0] - base_f < 8 || rev_sent[0] - base_r < 8) @(negedge clk);
    repeat (10) @(negedge clk);
    assert (fwd_sent[0] - base_f == 8 && rev_sent[0] - base_r == 8) else begin
      show_mismatch("accepted fwd/rev count col 0", {8'd8, 8'd8},
                    {8'(fwd_sent[0] - base_f), 8'(rev_sent[0] - base_r)});
      test_errors++;
    end
    assert (!sif_out[0].fwd.ready_and_rev && !sif_out[0].rev.ready_and_rev) else begin
      $display("Ready stayed high on column 0 after its eight credits were used");
      test_errors++;
    end
    ready_mode = 2;
    wait_idle();
    repeat (4) @(negedge clk);
    assert (sif_out[0].fwd.ready_and_rev && sif_out[0].rev.ready_and_rev) else begin
      $display("Ready did not come back on column 0 after the FIFO drained");
      test_errors++;
    end
    end_test(5, "back-pressure and credits");

    @(posedge clk);
    fwd_o_dis <= 2'b10;
    repeat (2) @(negedge clk);
    dis_chk = 1'b1;
    base_f = fwd_sent[1];
    fwd_req[0] += 12;
    rev_req[1] += 12;
    fwd_req[1] += 6;
    while (fwd_req[0] != fwd_sent[0] || rev_req[1] != rev_sent[1] ||
           fwd_q[0].size() != 0 || rev_q[1].size() != 0) @(negedge clk);
    assert (fwd_sent[1] == base_f) else begin
      show_mismatch("col 1 fwd accepts", 0, fwd_sent[1] - base_f);
      test_errors++;
    end
    fwd_req[1] = fwd_sent[1]; // Withdraw the packets the disabled channel never took
    @(negedge clk);
    dis_chk = 1'b0;
    @(posedge clk);
    fwd_o_dis <= '0;
    wait_idle();
    end_test(6, "disable");

    $display("tests run %0d, errors %0d", NUM_TESTS, chk_errors + test_errors);
    if (chk_errors + test_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/sdr_north_edge.sv */
`default_nettype none

module sdr_north_edge (
  input  wire logic                                             core_clk_i,
  input  wire logic                                             arst_n_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     core_reset_i,
  output logic [sdr_pkg::NUM_COLS-1:0][1:0]                     core_reset_o,

  input  wire sdr_pkg::link_sif_s [sdr_pkg::NUM_COLS-1:0]       core_link_sif_i,
  output sdr_pkg::link_sif_s [sdr_pkg::NUM_COLS-1:0]            core_link_sif_o,

  input  wire logic [sdr_pkg::NUM_COLS-1:0][sdr_pkg::X_W-1:0]   core_global_x_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0][sdr_pkg::Y_W-1:0]   core_global_y_i,
  output logic [sdr_pkg::NUM_COLS-1:0][sdr_pkg::X_W-1:0]        core_global_x_o,
  output logic [sdr_pkg::NUM_COLS-1:0][sdr_pkg::Y_W-1:0]        core_global_y_o,

  input  wire logic                                             async_uplink_reset_i,
  input  wire logic                                             async_downstream_reset_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     fwd_link_i_disable_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     fwd_link_o_disable_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     rev_link_i_disable_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     rev_link_o_disable_i,

  output sdr_pkg::fwd_packet_s [sdr_pkg::NUM_COLS-1:0]          io_fwd_link_data_o,
  output logic [sdr_pkg::NUM_COLS-1:0]                          io_fwd_link_v_o,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     io_fwd_link_token_i,
  input  wire sdr_pkg::fwd_packet_s [sdr_pkg::NUM_COLS-1:0]     io_fwd_link_data_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     io_fwd_link_v_i,
  output logic [sdr_pkg::NUM_COLS-1:0]                          io_fwd_link_token_o,

  output sdr_pkg::rev_packet_s [sdr_pkg::NUM_COLS-1:0]          io_rev_link_data_o,
  output logic [sdr_pkg::NUM_COLS-1:0]                          io_rev_link_v_o,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     io_rev_link_token_i,
  input  wire sdr_pkg::rev_packet_s [sdr_pkg::NUM_COLS-1:0]     io_rev_link_data_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]                     io_rev_link_v_i,
  output logic [sdr_pkg::NUM_COLS-1:0]                          io_rev_link_token_o
);

  sdr_pkg::chan_reset_s [sdr_pkg::NUM_COLS-1:0] fwd_reset;
  sdr_pkg::chan_reset_s [sdr_pkg::NUM_COLS-1:0] rev_reset;

  // One synchronizer pair serves the whole edge
  sdr_reset_ctrl reset_ctrl (
    .core_clk_i, .arst_n_i,
    .async_uplink_reset_i, .async_downstream_reset_i,
    .fwd_link_i_disable_i, .fwd_link_o_disable_i,
    .rev_link_i_disable_i, .rev_link_o_disable_i,
    .fwd_reset_o (fwd_reset),
    .rev_reset_o (rev_reset)
  );

  for (genvar c = 0; c < sdr_pkg::NUM_COLS; c++) begin : col
    sdr_link_north link (
      .core_clk_i, .arst_n_i,
      .core_reset_i        (core_reset_i[c]),        .core_reset_o        (core_reset_o[c]),
      .core_link_sif_i     (core_link_sif_i[c]),     .core_link_sif_o     (core_link_sif_o[c]),
      .core_global_x_i     (core_global_x_i[c]),     .core_global_y_i     (core_global_y_i[c]),
      .core_global_x_o     (core_global_x_o[c]),     .core_global_y_o     (core_global_y_o[c]),
      .fwd_reset_i         (fwd_reset[c]),           .rev_reset_i         (rev_reset[c]),
      .io_fwd_link_data_o  (io_fwd_link_data_o[c]),  .io_fwd_link_v_o     (io_fwd_link_v_o[c]),
      .io_fwd_link_token_i (io_fwd_link_token_i[c]), .io_fwd_link_data_i  (io_fwd_link_data_i[c]),
      .io_fwd_link_v_i     (io_fwd_link_v_i[c]),     .io_fwd_link_token_o (io_fwd_link_token_o[c]),
      .io_rev_link_data_o  (io_rev_link_data_o[c]),  .io_rev_link_v_o     (io_rev_link_v_o[c]),
      .io_rev_link_token_i (io_rev_link_token_i[c]), .io_rev_link_data_i  (io_rev_link_data_i[c]),
      .io_rev_link_v_i     (io_rev_link_v_i[c]),     .io_rev_link_token_o (io_rev_link_token_o[c])
    );
  end

endmodule

`default_nettype wire

/* hw/sdr_link_north.sv */
`default_nettype none

module sdr_link_north (
  input  wire logic                       core_clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       core_reset_i,
  output logic [1:0]                      core_reset_o,

  input  wire sdr_pkg::link_sif_s         core_link_sif_i,
  output sdr_pkg::link_sif_s              core_link_sif_o,

  input  wire logic [sdr_pkg::X_W-1:0]    core_global_x_i,
  input  wire logic [sdr_pkg::Y_W-1:0]    core_global_y_i,
  output logic [sdr_pkg::X_W-1:0]         core_global_x_o,
  output logic [sdr_pkg::Y_W-1:0]         core_global_y_o,

  input  wire sdr_pkg::chan_reset_s       fwd_reset_i,
  input  wire sdr_pkg::chan_reset_s       rev_reset_i,

  output sdr_pkg::fwd_packet_s            io_fwd_link_data_o,
  output logic                            io_fwd_link_v_o,
  input  wire logic                       io_fwd_link_token_i,
  input  wire sdr_pkg::fwd_packet_s       io_fwd_link_data_i,
  input  wire logic                       io_fwd_link_v_i,
  output logic                            io_fwd_link_token_o,

  output sdr_pkg::rev_packet_s            io_rev_link_data_o,
  output logic                            io_rev_link_v_o,
  input  wire logic                       io_rev_link_token_i,
  input  wire sdr_pkg::rev_packet_s       io_rev_link_data_i,
  input  wire logic                       io_rev_link_v_i,
  output logic                            io_rev_link_token_o
);

  logic                     core_reset_r;
  logic [sdr_pkg::X_W-1:0]  core_global_x_r;
  logic [sdr_pkg::Y_W-1:0]  core_global_y_r;

  sdr_pkg::chan_reset_s     fwd_reset;
  sdr_pkg::chan_reset_s     rev_reset;

  logic                     fwd_ready_lo, fwd_v_lo;
  logic                     rev_ready_lo, rev_v_lo;
  sdr_pkg::fwd_packet_s     fwd_data_lo;
  sdr_pkg::rev_packet_s     rev_data_lo;

  // Reset and coordinates are re-registered here so they can fan out across the die
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) core_reset_r <= 1'b0;
    else core_reset_r <= core_reset_i;
  end

  always_ff @(posedge core_clk_i) begin
    core_global_x_r <= core_global_x_i;
    core_global_y_r <= core_global_y_i;
  end

  assign core_reset_o    = {2{core_reset_r}};
  assign core_global_x_o = core_global_x_r;
  assign core_global_y_o = core_global_y_r;

  // Local core reset holds all four channel halves
  assign fwd_reset.uplink_reset     = fwd_reset_i.uplink_reset | core_reset_r;
  assign fwd_reset.downstream_reset = fwd_reset_i.downstream_reset | core_reset_r;
  assign rev_reset.uplink_reset     = rev_reset_i.uplink_reset | core_reset_r;
  assign rev_reset.downstream_reset = rev_reset_i.downstream_reset | core_reset_r;

  sdr_credit_tx #(.payload_t(sdr_pkg::fwd_packet_s)) fwd_tx (
    .core_clk_i, .arst_n_i,
    .uplink_reset_i (fwd_reset.uplink_reset),
    .core_v_i       (core_link_sif_i.fwd.v),
    .core_data_i    (core_link_sif_i.fwd.data),
    .core_ready_o   (fwd_ready_lo),
    .link_v_o       (io_fwd_link_v_o),
    .link_data_o    (io_fwd_link_data_o),
    .link_token_i   (io_fwd_link_token_i)
  );

  sdr_credit_rx #(.payload_t(sdr_pkg::fwd_packet_s)) fwd_rx (
    .core_clk_i, .arst_n_i,
    .downstream_reset_i (fwd_reset.downstream_reset),
    .link_v_i           (io_fwd_link_v_i),
    .link_data_i        (io_fwd_link_data_i),
    .link_token_o       (io_fwd_link_token_o),
    .core_v_o           (fwd_v_lo),
    .core_data_o        (fwd_data_lo),
    .core_ready_i       (core_link_sif_i.fwd.ready_and_rev)
  );

  sdr_credit_tx #(.payload_t(sdr_pkg::rev_packet_s)) rev_tx (
    .core_clk_i, .arst_n_i,
    .uplink_reset_i (rev_reset.uplink_reset),
    .core_v_i       (core_link_sif_i.rev.v),
    .core_data_i    (core_link_sif_i.rev.data),
    .core_ready_o   (rev_ready_lo),
    .link_v_o       (io_rev_link_v_o),
    .link_data_o    (io_rev_link_data_o),
    .link_token_i   (io_rev_link_token_i)
  );

  sdr_credit_rx #(.payload_t(sdr_pkg::rev_packet_s)) rev_rx (
    .core_clk_i, .arst_n_i,
    .downstream_reset_i (rev_reset.downstream_reset),
    .link_v_i           (io_rev_link_v_i),
    .link_data_i        (io_rev_link_data_i),
    .link_token_o       (io_rev_link_token_o),
    .core_v_o           (rev_v_lo),
    .core_data_o        (rev_data_lo),
    .core_ready_i       (core_link_sif_i.rev.ready_and_rev)
  );

  always_comb begin
    core_link_sif_o.fwd.v             = fwd_v_lo;
    core_link_sif_o.fwd.data          = fwd_data_lo;
    core_link_sif_o.fwd.ready_and_rev = fwd_ready_lo; // Transmitter can take a packet
    core_link_sif_o.rev.v             = rev_v_lo;
    core_link_sif_o.rev.data          = rev_data_lo;
    core_link_sif_o.rev.ready_and_rev = rev_ready_lo;
  end

endmodule

`default_nettype wire

/* hw/sdr_credit_rx.sv */
`default_nettype none

module sdr_credit_rx #(
  parameter type payload_t = logic
) (
  input  wire logic     core_clk_i,
  input  wire logic     arst_n_i,
  input  wire logic     downstream_reset_i,

  input  wire logic     link_v_i,
  input  wire payload_t link_data_i,
  output logic          link_token_o,

  output logic          core_v_o,
  output payload_t      core_data_o,
  input  wire logic     core_ready_i
);

  payload_t mem_r [sdr_pkg::FIFO_DEPTH];

  logic [sdr_pkg::LG_FIFO_DEPTH-1:0] wr_ptr_r;
  logic [sdr_pkg::LG_FIFO_DEPTH-1:0] rd_ptr_r;
  logic [sdr_pkg::LG_FIFO_DEPTH:0]   count_r;
  logic [sdr_pkg::LG_FIFO_DEPTH:0]   count_next;
  logic [sdr_pkg::LG_DECIMATION-1:0] dec_cnt_r;
  logic                              token_r;
  logic                              enq;
  logic                              deq;

  // The sender's credits guarantee a free entry for every valid it sends
  assign enq = link_v_i & ~downstream_reset_i;
  assign deq = core_v_o & core_ready_i;

  // Fall-through read, the head entry is visible as soon as it is written
  assign core_v_o    = (count_r != '0);
  assign core_data_o = mem_r[rd_ptr_r];

  always_comb begin
    count_next = count_r;
    if (enq) count_next = count_next + 1'b1;
    if (deq) count_next = count_next - 1'b1;
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else if (downstream_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) wr_ptr_r <= wr_ptr_r + 1'b1; // Pointers wrap with the depth
      if (deq) rd_ptr_r <= rd_ptr_r + 1'b1;
      count_r <= count_next;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (enq) mem_r[wr_ptr_r] <= link_data_i;
  end

  // Token fires on the dequeue that wraps the decimation counter
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_cnt_r <= '0;
      token_r   <= 1'b0;
    end else if (downstream_reset_i) begin
      dec_cnt_r <= '0;
      token_r   <= 1'b0;
    end else begin
      if (deq) dec_cnt_r <= dec_cnt_r + 1'b1;
      token_r <= deq & (dec_cnt_r == '1);
    end
  end

  assign link_token_o = token_r;

endmodule

`default_nettype wire

/* hw/sdr_credit_tx.sv */
`default_nettype none

module sdr_credit_tx #(
  parameter type payload_t = logic
) (
  input  wire logic     core_clk_i,
  input  wire logic     arst_n_i,
  input  wire logic     uplink_reset_i,

  input  wire logic     core_v_i,
  input  wire payload_t core_data_i,
  output logic          core_ready_o,

  output logic          link_v_o,
  output payload_t      link_data_o,
  input  wire logic     link_token_i
);

  logic [sdr_pkg::CREDIT_W-1:0] credit_r;
  logic [sdr_pkg::CREDIT_W-1:0] credit_next;
  logic                         accept;
  logic                         link_v_r;
  payload_t                     link_data_r;

  assign core_ready_o = (credit_r != '0) & ~uplink_reset_i;
  assign accept       = core_v_i & core_ready_o;

  // A token and an accept can land in the same cycle
  always_comb begin
    credit_next = credit_r;
    if (accept) credit_next = credit_next - 1'b1;
    if (link_token_i) credit_next = credit_next + sdr_pkg::TOKEN_CREDITS;
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_r <= sdr_pkg::INIT_CREDITS;
      link_v_r <= 1'b0;
    end else if (uplink_reset_i) begin
      credit_r <= sdr_pkg::INIT_CREDITS;
      link_v_r <= 1'b0;
    end else begin
      credit_r <= credit_next;
      link_v_r <= accept; // One pulse per packet
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (accept) link_data_r <= core_data_i;
  end

  assign link_v_o    = link_v_r;
  assign link_data_o = link_data_r;

endmodule

`default_nettype wire

/* hw/sdr_reset_ctrl.sv */
`default_nettype none

module sdr_reset_ctrl (
  input  wire logic                          core_clk_i,
  input  wire logic                          arst_n_i,

  input  wire logic                          async_uplink_reset_i,
  input  wire logic                          async_downstream_reset_i,

  input  wire logic [sdr_pkg::NUM_COLS-1:0]  fwd_link_i_disable_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]  fwd_link_o_disable_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]  rev_link_i_disable_i,
  input  wire logic [sdr_pkg::NUM_COLS-1:0]  rev_link_o_disable_i,

  output sdr_pkg::chan_reset_s [sdr_pkg::NUM_COLS-1:0] fwd_reset_o,
  output sdr_pkg::chan_reset_s [sdr_pkg::NUM_COLS-1:0] rev_reset_o
);

  // Two-stage synchronizers, bit 1 is the settled value
  logic [1:0] uplink_sync_r;
  logic [1:0] downstream_sync_r;

  logic uplink_reset;
  logic downstream_reset;

  // Channels come out of a global reset still held, until the inputs are seen low
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      uplink_sync_r     <= 2'b11;
      downstream_sync_r <= 2'b11;
    end else begin
      uplink_sync_r     <= {uplink_sync_r[0], async_uplink_reset_i};
      downstream_sync_r <= {downstream_sync_r[0], async_downstream_reset_i};
    end
  end

  assign uplink_reset     = uplink_sync_r[1];
  assign downstream_reset = downstream_sync_r[1];

  // Output disables hold the transmit half, input disables hold the receive half
  always_comb begin
    for (int c = 0; c < sdr_pkg::NUM_COLS; c++) begin
      fwd_reset_o[c].uplink_reset     = uplink_reset | fwd_link_o_disable_i[c];
      fwd_reset_o[c].downstream_reset = downstream_reset | fwd_link_i_disable_i[c];
      rev_reset_o[c].uplink_reset     = uplink_reset | rev_link_o_disable_i[c];
      rev_reset_o[c].downstream_reset = downstream_reset | rev_link_i_disable_i[c];
    end
  end

endmodule

`default_nettype wire

/* hw/sdr_pkg.sv */
`default_nettype none

package sdr_pkg;

  // Edge geometry and packet field widths
  localparam int NUM_COLS = 2;
  localparam int ADDR_W   = 8;
  localparam int DATA_W   = 16;
  localparam int X_W      = 4;
  localparam int Y_W      = 3;

  // Receive FIFO depth sets the initial credit count on the transmit side
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;

  // One token goes back for every 2^LG_DECIMATION dequeued packets
  localparam int LG_DECIMATION = 1;

  localparam int CREDIT_W = LG_FIFO_DEPTH + 1; // Must hold the full depth
  localparam logic [CREDIT_W-1:0] INIT_CREDITS  = CREDIT_W'(FIFO_DEPTH);
  localparam logic [CREDIT_W-1:0] TOKEN_CREDITS = CREDIT_W'(1 << LG_DECIMATION);

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [X_W-1:0]    src_x;
    logic [Y_W-1:0]    src_y;
  } fwd_packet_s;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [X_W-1:0]    dst_x;
    logic [Y_W-1:0]    dst_y;
  } rev_packet_s;

  // Valid and data flow one way, ready_and_rev flows back against them
  typedef struct packed {
    logic        v;
    fwd_packet_s data;
    logic        ready_and_rev;
  } fwd_chan_s;

  typedef struct packed {
    logic        v;
    rev_packet_s data;
    logic        ready_and_rev;
  } rev_chan_s;

  typedef struct packed {
    fwd_chan_s fwd;
    rev_chan_s rev;
  } link_sif_s;

  typedef struct packed {
    logic uplink_reset;
    logic downstream_reset;
  } chan_reset_s;

endpackage

`default_nettype wire
